//--- project.f
+incdir+.
ts_time_pkg.sv
ts_msg_pkg.sv
rtc_counter.sv
pulse_cross_clock.sv
timestamp_snapshot.sv
ts_msg_receiver.sv
ts_snapshot_top.sv
tb_ts_snapshot.sv

//--- tb_ts_snapshot.sv
// assumes the ts_params.svh defaults; captured usec is checked within a few usec of crossing skew
`timescale 1ns/100ps
`include "ts_params.svh"

module tb_ts_snapshot;
    import ts_time_pkg::*;
    import ts_msg_pkg::*;

    localparam int SCLK_PERIOD = 4;
    localparam int NUM_ROWS    = 6;
    localparam int USEC_TOL    = 3;    // load vs snap crossing skew, in usec
    localparam int ROW_MARGIN  = 150;  // sclk cycles per row for crossings and bytes
    localparam int PRE_LIMIT   = 100;  // sclk cycles allowed until pre_stb
    localparam int INJ_NONE    = 0;
    localparam int INJ_ABORT   = 1;    // second snap during bytes 2..5
    localparam int INJ_BUSY    = 2;    // second snap while snap_busy

    typedef struct packed {
        ts_time_t    load;
        logic [15:0] wait_cyc;  // sclk cycles from set_stb to snap
        logic [1:0]  inject;
        logic [1:0]  sec_inc;   // expected sec step at capture
    } row_t;

    logic        sclk;
    logic        tclk;
    logic        srst;
    logic        snap;
    logic        set_stb;
    ts_time_t    set_time;
    ts_stream_t  stream;
    logic        snap_busy;
    ts_time_t    ts_out;
    logic        ts_valid;
    row_t        rows [NUM_ROWS];
    int          tclk_cnt = 0;    // own tclk edge count
    int          pre_seen = 0;
    int          valid_seen = 0;
    int          snaps_ok = 0;    // snaps issued with snap_busy low
    bit          table_ready = 1'b0;
    int unsigned seed;

    ts_snapshot_top dut (
        .sclk      (sclk),
        .tclk      (tclk),
        .srst      (srst),
        .snap      (snap),
        .set_stb   (set_stb),
        .set_time  (set_time),
        .stream    (stream),
        .snap_busy (snap_busy),
        .ts_out    (ts_out),
        .ts_valid  (ts_valid)
    );

    initial begin
        sclk = 1'b0;
        forever #(SCLK_PERIOD / 2) sclk = ~sclk;
    end

    initial begin
        tclk = 1'b0;
        forever #5 tclk = ~tclk;  // 10 ns, unrelated to sclk
    end

    always @(posedge tclk) tclk_cnt <= tclk_cnt + 1;

    always @(negedge sclk) begin
        if (!srst && stream.pre_stb) pre_seen++;
        if (!srst && ts_valid) valid_seen++;
    end

    function automatic row_t make_row(ts_sec_t sec, ts_usec_t usec, int wait_cyc, int inject,
                                      int sec_inc);
        row_t r;
        r.load.sec  = sec;
        r.load.usec = usec;
        r.wait_cyc  = 16'(wait_cyc);
        r.inject    = 2'(inject);
        r.sec_inc   = 2'(sec_inc);
        return r;
    endfunction

    // byte k of a message, little-endian from sec bit 0
    function automatic ts_byte_t msg_byte(ts_time_t t, int k);
        case (k)
            0:       return t.sec[7:0];
            1:       return t.sec[15:8];
            2:       return t.sec[23:16];
            3:       return t.sec[31:24];
            4:       return t.usec[7:0];
            5:       return t.usec[15:8];
            6:       return {4'h0, t.usec[19:16]};  // upper nibble zero
            default: return 8'h00;                  // pad byte
        endcase
    endfunction

    // loaded time advanced by the tclk cycles counted here
    function automatic ts_time_t expect_time(row_t r, int elapsed);
        ts_time_t e;
        int       u;
        u = int'(r.load.usec) + elapsed / `TS_USEC_DIV;
        if (u >= `TS_USEC_WRAP) u = u - `TS_USEC_WRAP;  // at most one rollover per row
        e.sec  = r.load.sec + ts_sec_t'(r.sec_inc);
        e.usec = ts_usec_t'(u);
        return e;
    endfunction

    task automatic fail_now();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_time(string name, ts_time_t got, ts_time_t exp, int tol);
        int diff;
        diff = int'(got.usec) - int'(exp.usec);
        if ($isunknown(got) || got.sec !== exp.sec || diff > tol || diff < -tol) begin
            $display("[ERROR] %0t %s got sec=%0d usec=%0d expected sec=%0d usec=%0d (+/-%0d)",
                     $time, name, got.sec, got.usec, exp.sec, exp.usec, tol);
            fail_now();
        end
    endtask

    task automatic check_byte(string name, ts_byte_t got, ts_byte_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic send_snap();
        snap = 1'b1;
        if (!snap_busy) snaps_ok++;  // accepted only when idle
        @(negedge sclk);
        snap = 1'b0;
    endtask

    // returns at the negedge that shows pre_stb
    task automatic wait_pre_stb(input bit no_valid);
        int n;
        n = 0;
        while (!stream.pre_stb) begin
            if (no_valid && ts_valid) begin
                $display("ts_valid was raised for an aborted message");
                fail_now();
            end
            if (n == PRE_LIMIT) begin
                $display("pre_stb did not appear within %0d sclk cycles", PRE_LIMIT);
                fail_now();
            end
            @(negedge sclk);
            n++;
        end
    endtask

    task automatic capture_message(output ts_time_t got);
        ts_byte_t bytes [`TS_MSG_BYTES];
        for (int n = 1; n <= `TS_MSG_BYTES + 2; n++) begin
            @(negedge sclk);
            if (n >= 2 && n <= `TS_MSG_BYTES + 1) begin
                bytes[n-2] = stream.data;  // byte k at pre_stb + k + 2
            end else if (n == `TS_MSG_BYTES + 2 && ts_valid !== 1'b1) begin
                $display("ts_valid missing %0d cycles after pre_stb", n);
                fail_now();
            end
        end
        got = ts_out;
        for (int k = 0; k < `TS_MSG_BYTES; k++) begin
            check_byte($sformatf("stream.data byte %0d", k), bytes[k], msg_byte(got, k));
        end
    endtask

    task automatic run_row(row_t r);
        int       t0;
        int       elapsed;
        int       k;
        ts_time_t got;
        set_time = r.load;  // stays put for the whole row
        set_stb  = 1'b1;
        t0       = tclk_cnt;
        @(negedge sclk);
        set_stb = 1'b0;
        repeat (int'(r.wait_cyc) + int'($urandom % 4)) @(negedge sclk);  // jitter
        elapsed = tclk_cnt - t0;
        send_snap();
        if (r.inject == INJ_BUSY) begin
            @(negedge sclk);
            if (snap_busy !== 1'b1) begin
                $display("snap_busy is not high after an accepted snap");
                fail_now();
            end
            send_snap();  // lost, no pre_stb of its own
        end
        wait_pre_stb(1'b0);
        if (r.inject == INJ_ABORT) begin
            k = 2 + int'($urandom % 4);
            repeat (k + 2) @(negedge sclk);  // byte k on the bus
            elapsed = tclk_cnt - t0;          // the retry captures this later time
            send_snap();
            wait_pre_stb(1'b1);
        end
        capture_message(got);
        check_time("ts_out", got, expect_time(r, elapsed), USEC_TOL);
        repeat (20) @(negedge sclk);  // set_xclk round trip done
    endtask

    initial begin
        int total;
        wait (table_ready);
        total = 100;  // reset and drain
        for (int i = 0; i < NUM_ROWS; i++) total += int'(rows[i].wait_cyc) + ROW_MARGIN;
        #(total * SCLK_PERIOD);
        $display("watchdog expired after %0d sclk cycles, the DUT stopped responding", total);
        fail_now();
    end

    initial begin
        srst     = 1'b1;
        snap     = 1'b0;
        set_stb  = 1'b0;
        set_time = '0;
        seed     = 32'h9be08de1;
        void'($urandom(seed));
        rows[0] = make_row(32'd100, 20'd1000, 30, INJ_NONE, 0);
        rows[1] = make_row(32'd7, ts_usec_t'(`TS_USEC_WRAP - 2), 50, INJ_NONE, 1);  // rollover
        rows[2] = make_row(32'h12345678, 20'he1234, 25, INJ_ABORT, 0);
        rows[3] = make_row(32'hdeadbeef, 20'h54321, 40, INJ_BUSY, 0);
        rows[4] = make_row(32'd1, ts_usec_t'(`TS_USEC_WRAP - 1), 30, INJ_ABORT, 1);
        rows[5] = make_row(32'hffffffff, ts_usec_t'(`TS_USEC_WRAP - 3), 60, INJ_NONE, 1);
        table_ready = 1'b1;
        repeat (2) @(negedge sclk);
        repeat (4) @(negedge sclk);  // long enough for tclk too
        srst = 1'b0;
        repeat (5) @(negedge sclk);
        for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i]);
        repeat (40) @(negedge sclk);  // a late stray pre_stb would land here
        if (pre_seen != snaps_ok) begin
            $display("[ERROR] %0t pre_stb count got %0d expected %0d", $time, pre_seen, snaps_ok);
            fail_now();
        end else if (valid_seen != NUM_ROWS) begin
            $display("[ERROR] %0t ts_valid count got %0d expected %0d", $time, valid_seen,
                     NUM_ROWS);
            fail_now();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- ts_snapshot_top.sv
// srst must cover both clocks; set_time held from set_stb until the load lands in tclk
`timescale 1ns/100ps
`include "ts_params.svh"

module ts_snapshot_top (
    input  logic                   sclk,
    input  logic                   tclk,
    input  logic                   srst,
    input  logic                   snap,       // single sclk pulse
    input  logic                   set_stb,    // single sclk pulse
    input  ts_time_pkg::ts_time_t  set_time,
    output ts_msg_pkg::ts_stream_t stream,
    output logic                   snap_busy,
    output ts_time_pkg::ts_time_t  ts_out,
    output logic                   ts_valid
);
    import ts_time_pkg::*;

    logic     load;      // set_stb in tclk
    ts_time_t cur_time;  // running time, tclk

    pulse_cross_clock #(
        .EXTRA_DLY (`TS_SET_DLY)
    ) set_xclk (
        .srst      (srst),
        .src_clk   (sclk),
        .dst_clk   (tclk),
        .in_pulse  (set_stb),
        .out_pulse (load),
        .busy      ()           // back-to-back loads not supported
    );

    rtc_counter rtc_counter_i (
        .tclk     (tclk),
        .srst     (srst),
        .load     (load),
        .set_time (set_time),
        .cur_time (cur_time)
    );

    timestamp_snapshot timestamp_snapshot_i (
        .tclk      (tclk),
        .sclk      (sclk),
        .srst      (srst),
        .cur_time  (cur_time),
        .snap      (snap),
        .snap_busy (snap_busy),
        .stream    (stream)
    );

    ts_msg_receiver ts_msg_receiver_i (
        .sclk     (sclk),
        .srst     (srst),
        .stream   (stream),
        .ts_out   (ts_out),
        .ts_valid (ts_valid)
    );

endmodule

//--- ts_msg_receiver.sv
// expects pre_stb, one idle slot, then 8 back-to-back bytes; anything else is dropped silently
`timescale 1ns/100ps
`include "ts_params.svh"

module ts_msg_receiver (
    input  logic                   sclk,
    input  logic                   srst,
    input  ts_msg_pkg::ts_stream_t stream,
    output ts_time_pkg::ts_time_t  ts_out,
    output logic                   ts_valid   // 10 cycles after pre_stb
);
    import ts_time_pkg::*;
    import ts_msg_pkg::*;

    localparam int MSG_W = 8 * `TS_MSG_BYTES;
    localparam int TIME_W = $bits(ts_time_t);
    localparam ts_idx_t LAST_IDX = ts_idx_t'(`TS_MSG_BYTES - 1);

    logic             armed;      // idle slot after pre_stb
    logic             rx_on;      // byte slots in progress
    ts_idx_t          pos;        // current byte position
    logic [MSG_W-1:0] asm_word;   // shift-in, newest byte on top
    logic [MSG_W-1:0] asm_next;
    logic             last_slot;  // byte 7 slot, in sequence
    logic             msg_ok;

    assign asm_next  = {stream.data, asm_word[MSG_W-1:8]};
    assign last_slot = rx_on && !stream.pre_stb && (pos == LAST_IDX);

    // pad byte and byte 6 upper nibble must be zero, idle fill fails here
    assign msg_ok = (asm_next[MSG_W-1:TIME_W] == '0);

    always_ff @(posedge sclk) begin
        if (srst) begin
            armed    <= 1'b0;
            rx_on    <= 1'b0;
            pos      <= '0;
            ts_valid <= 1'b0;
        end else begin
            ts_valid <= last_slot && msg_ok;
            if (stream.pre_stb) begin
                armed <= 1'b1;  // restart, partial message dropped
                rx_on <= 1'b0;
            end else if (armed) begin
                armed <= 1'b0;  // skip idle slot
                rx_on <= 1'b1;
                pos   <= '0;
            end else if (rx_on) begin
                pos <= pos + 1'b1;
                if (pos == LAST_IDX) begin
                    rx_on <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (rx_on) begin
            asm_word <= asm_next;
        end
        if (last_slot && msg_ok) begin
            ts_out <= ts_time_t'(asm_next[TIME_W-1:0]);
        end
    end

    valid_usec_a: assert property (
        @(posedge sclk) disable iff (srst)
        ts_valid |-> (ts_out.usec < `TS_USEC_WRAP)
    ) else $error("received usec out of range: %0d", ts_out.usec);

endmodule

//--- timestamp_snapshot.sv
// snap during snap_busy is dropped; a snap while sending aborts the message, bus idles at 8'hff
`timescale 1ns/100ps
`include "ts_params.svh"

module timestamp_snapshot (
    input  logic                   tclk,
    input  logic                   sclk,
    input  logic                   srst,
    input  ts_time_pkg::ts_time_t  cur_time,   // tclk domain
    input  logic                   snap,       // single sclk pulse
    output logic                   snap_busy,
    output ts_msg_pkg::ts_stream_t stream
);
    import ts_time_pkg::*;
    import ts_msg_pkg::*;

    localparam int MSG_W = 8 * `TS_MSG_BYTES;
    localparam ts_byte_t IDLE_BYTE = 8'hff;  // never a legal byte 7

    logic             snap_tclk;  // crossed snapshot strobe
    ts_time_t         snap_time;  // latched in tclk
    logic [MSG_W-1:0] msg_word;   // zero padded message image
    logic             busy_r;
    logic             pre_stb;
    logic             snd;        // byte slots running
    ts_idx_t          byte_idx;
    ts_byte_t         data_r;

    pulse_cross_clock #(
        .EXTRA_DLY (`TS_SNAP_DLY)
    ) snap_xclk (
        .srst      (srst),
        .src_clk   (sclk),
        .dst_clk   (tclk),
        .in_pulse  (snap),
        .out_pulse (snap_tclk),
        .busy      (snap_busy)
    );

    always_ff @(posedge tclk) begin
        if (snap_tclk) begin
            snap_time <= cur_time;
        end
    end

    // snap_time settled long before busy drops, read directly in sclk
    assign msg_word = {{(MSG_W - $bits(ts_time_t)){1'b0}}, snap_time};

    // round trip done, latched time is stable
    assign pre_stb = busy_r && !snap_busy;

    always_ff @(posedge sclk) begin
        if (srst) begin
            busy_r <= 1'b0;
            snd    <= 1'b0;
        end else begin
            busy_r <= snap_busy;
            if (pre_stb) begin
                snd <= 1'b1;
            end else if ((&byte_idx) || snap) begin
                snd <= 1'b0;  // last byte or abort
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (srst) begin
            byte_idx <= '0;
        end else if (!snd) begin
            byte_idx <= '0;
        end else begin
            byte_idx <= byte_idx + 1'b1;
        end
    end

    // byte k out two cycles after pre_stb + k
    always_ff @(posedge sclk) begin
        if (snd) begin
            data_r <= msg_word[8*byte_idx +: 8];
        end else begin
            data_r <= IDLE_BYTE;
        end
    end

    assign stream = '{pre_stb: pre_stb, data: data_r};

    // crossing round trip outlasts a message so no pre_stb lands on a running counter
    pre_stb_idle_a: assert property (
        @(posedge sclk) disable iff (srst)
        pre_stb |-> !snd
    ) else $error("pre_stb while the byte counter runs");

endmodule

//--- pulse_cross_clock.sv
// one pulse per round trip; srst is used in both domains and must span several slow-clock cycles
`timescale 1ns/100ps

module pulse_cross_clock #(
    parameter int EXTRA_DLY = 0  // extra destination sync stages
) (
    input  logic srst,
    input  logic src_clk,
    input  logic dst_clk,
    input  logic in_pulse,   // single src_clk pulse
    output logic out_pulse,  // single dst_clk pulse
    output logic busy        // round trip pending, in_pulse ignored
);
    localparam int SYNC_LEN = 2 + EXTRA_DLY;

    logic                src_tgl;   // flips once per accepted pulse
    logic [1:0]          ack_sync;  // dst level back in src_clk
    logic [SYNC_LEN-1:0] dst_sync;  // src_tgl into dst_clk
    logic                dst_lvl;   // last level seen in dst, also the ack

    // busy until the ack matches the toggle
    assign busy = src_tgl ^ ack_sync[1];

    // edge of the synchronized toggle
    assign out_pulse = dst_sync[SYNC_LEN-1] ^ dst_lvl;

    always_ff @(posedge src_clk) begin
        if (srst) begin
            src_tgl  <= 1'b0;
            ack_sync <= '0;
        end else begin
            if (in_pulse && !busy) begin
                src_tgl <= ~src_tgl;  // pulse during busy is lost
            end
            ack_sync <= {ack_sync[0], dst_lvl};
        end
    end

    always_ff @(posedge dst_clk) begin
        if (srst) begin
            dst_sync <= '0;
            dst_lvl  <= 1'b0;
        end else begin
            dst_sync <= {dst_sync[SYNC_LEN-2:0], src_tgl};
            dst_lvl  <= dst_sync[SYNC_LEN-1];
        end
    end

    // holds only if busy keeps toggles one round trip apart
    single_pulse_a: assert property (
        @(posedge dst_clk) disable iff (srst)
        out_pulse |=> !out_pulse
    ) else $error("out_pulse held for more than one dst_clk cycle");

endmodule

//--- rtc_counter.sv
// tclk domain only; srst must span several tclk cycles and set_time is sampled on load alone
`timescale 1ns/100ps
`include "ts_params.svh"

module rtc_counter (
    input  logic                  tclk,
    input  logic                  srst,
    input  logic                  load,      // single tclk pulse
    input  ts_time_pkg::ts_time_t set_time,  // held stable around load
    output ts_time_pkg::ts_time_t cur_time
);
    import ts_time_pkg::*;

    localparam int PRE_W = ($clog2(`TS_USEC_DIV) > 0) ? $clog2(`TS_USEC_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`TS_USEC_DIV - 1);
    localparam ts_usec_t USEC_LAST = ts_usec_t'(`TS_USEC_WRAP - 1);

    logic [PRE_W-1:0] pre_cnt;    // tclk cycles inside current usec
    logic             usec_tick;  // last prescaler cycle

    assign usec_tick = (pre_cnt == PRE_LAST);

    always_ff @(posedge tclk) begin
        if (srst) begin
            pre_cnt  <= '0;
            cur_time <= '0;
        end else if (load) begin
            pre_cnt  <= '0;        // new usec phase starts with the load
            cur_time <= set_time;  // visible one tclk after load
        end else begin
            pre_cnt <= usec_tick ? '0 : pre_cnt + 1'b1;
            if (usec_tick) begin
                if (cur_time.usec == USEC_LAST) begin
                    cur_time.usec <= '0;                    // second boundary
                    cur_time.sec  <= cur_time.sec + 32'd1;
                end else begin
                    cur_time.usec <= cur_time.usec + 20'd1;
                end
            end
        end
    end

    // a bad set_time from the sclk side would show up here
    usec_range_a: assert property (
        @(posedge tclk) disable iff (srst)
        cur_time.usec < `TS_USEC_WRAP
    ) else $error("rtc usec out of range: %0d", cur_time.usec);

endmodule

//--- ts_msg_pkg.sv
// byte-stream types for the fixed 8-byte timestamp message; no back-pressure on the bus
`include "ts_params.svh"

package ts_msg_pkg;

    // one message byte, little-endian order on the bus
    typedef logic [7:0] ts_byte_t;

    // byte position inside a message
    typedef logic [$clog2(`TS_MSG_BYTES)-1:0] ts_idx_t;

    // snapshot -> receiver bus
    typedef struct packed {
        logic     pre_stb;  // one cycle ahead of the idle slot
        ts_byte_t data;     // byte k two cycles after pre_stb + k
    } ts_stream_t;

endpackage

//--- ts_time_pkg.sv
// time-of-day types; whole microseconds only, field order follows the message byte order
package ts_time_pkg;

    // seconds since load, free running
    typedef logic [31:0] ts_sec_t;

    // microseconds inside the second, 0 .. TS_USEC_WRAP-1
    typedef logic [19:0] ts_usec_t;

    // 52 bits, sec in the low word so byte 0 of the message is sec[7:0]
    typedef struct packed {
        ts_usec_t usec;  // bits 51:32
        ts_sec_t  sec;   // bits 31:0
    } ts_time_t;

endpackage

//--- ts_params.svh
// simulation defaults; TS_USEC_DIV must equal the tclk rate in MHz for true microseconds
`ifndef TS_PARAMS_SVH
`define TS_PARAMS_SVH

// rtc counter rates
`define TS_USEC_DIV   2        // tclk cycles per usec tick
`define TS_USEC_WRAP  1000000  // usec count that carries into seconds

// message format, fixed length only
`define TS_MSG_BYTES  8        // bytes per timestamp message

// clock crossing depth, added to the 2-stage synchronizer
`define TS_SNAP_DLY   1        // snapshot pulse, sclk -> tclk
`define TS_SET_DLY    0        // load pulse, sclk -> tclk

`endif
